// File: source/mem_params.svh
// Memory subsystem parameters
// Gives the byte address map of the two SRAM banks and their depths in 32-bit words.
// Both windows are equal in size, and each bank fills only the lower part of its window.

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// depth of bank 0 in 32-bit words
`define MEM_BANK0_WORDS 256

// depth of bank 1 in 32-bit words
`define MEM_BANK1_WORDS 128

// byte base address of each bank window
`define MEM_BANK0_BASE 32'h0000_0000
`define MEM_BANK1_BASE 32'h0000_1000

// size in bytes of the decode window of one bank
// words past the bank depth inside a window are unmapped
`define MEM_BANK_SPAN 32'h0000_1000

`endif

// File: source/mem_pkg.sv
// Memory subsystem package
// Holds the types shared by the Wishbone bank slaves and the address decoder.

package mem_pkg;

    // state of the ack generator in each bank slave
    // a write goes from idle straight to done
    // a read passes through the wait state because the RAM output is registered
    typedef enum logic [1:0] {
        ACK_IDLE      = 2'd0,
        ACK_READ_WAIT = 2'd1,
        ACK_DONE      = 2'd2
    } ack_state_e;

    // target of the bus cycle that is currently on the top-level bus
    // TGT_NONE covers every unmapped or misaligned address
    typedef enum logic [1:0] {
        TGT_BANK0 = 2'd0,
        TGT_BANK1 = 2'd1,
        TGT_NONE  = 2'd2
    } wb_target_e;

endpackage

// File: source/wb_if.sv
// Wishbone classic bus bundle
// Connects the address decoder, which acts as master, to one bank slave.

`timescale 1ns/1ps

interface wb_if;

    // address, already offset into the bank window by the decoder
    logic [31:0] adr;
    // write data from the master and read data from the slave
    logic [31:0] dat_m2s;
    logic [31:0] dat_s2m;
    // byte lane selects, bit 0 is the lowest byte
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
    // single-cycle response pulse
    logic        ack;

    // the decoder side drives the request
    modport master (
        output adr, dat_m2s, sel, we, cyc, stb,
        input  dat_s2m, ack
    );

    // the bank side answers with data and ack
    modport slave (
        input  adr, dat_m2s, sel, we, cyc, stb,
        output dat_s2m, ack
    );

endinterface

// File: source/soc_mem.sv
// Behavioral single-port SRAM
// Synchronous read, per-byte write enables, one 32-bit word per address.
// Stands in for a hard SRAM macro of the same port shape.

`timescale 1ns/1ps

module soc_mem #(
    parameter int WORDS = 256
) (
    input  logic                     wb_clk_i,
    input  logic                     ena_i,
    input  logic [3:0]               wen_i,
    input  logic [$clog2(WORDS)-1:0] addr_i,
    input  logic [31:0]              wdata_i,
    output logic [31:0]              rdata_o
);

    // storage is kept as four byte lanes per word
    // so that each lane can be written on its own
    logic [3:0][7:0] mem_q [WORDS];

    // write port
    // only the lanes with their enable set are updated
    // an access with no lane enabled leaves the word alone
    always_ff @(posedge wb_clk_i) begin
        if (ena_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wen_i[lane]) begin
                    mem_q[addr_i][lane] <= wdata_i[8*lane +: 8];
                end
            end
        end
    end

    // read port
    // data appears one cycle after the enable is sampled and holds until the next enable
    // a write in the same cycle returns the old content of the word
    always_ff @(posedge wb_clk_i) begin
        if (ena_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// File: source/mem_wb.sv
// Wishbone bank slave
// Wraps one soc_mem and turns classic Wishbone requests into RAM accesses.
// Writes are acknowledged one cycle after the request and reads two cycles after.
// Each request gets a single ack and the slave then waits for stb to drop.

`timescale 1ns/1ps

module mem_wb #(
    parameter int WORDS = 256
) (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    wb_if.slave  bus
);

    // width of the word address into the RAM
    localparam int ADR_W = $clog2(WORDS);

    logic                valid;
    logic                wr_req;
    logic [3:0]          wen;
    logic [ADR_W-1:0]    word_adr;
    mem_pkg::ack_state_e state_q;
    mem_pkg::ack_state_e state_d;
    logic                ack_q;
    logic                ack_d;

    // a request is live while both cyc and stb are high
    assign valid = bus.cyc & bus.stb;

    // only the first cycle of a write reaches the RAM
    // so a master that keeps stb high after the ack does not write again
    assign wr_req = valid & bus.we & (state_q == mem_pkg::ACK_IDLE);

    // byte write enables come straight from sel
    assign wen = bus.sel & {4{wr_req}};

    // the address is a byte address, drop the two low bits
    assign word_adr = bus.adr[ADR_W+1:2];

    // next state and ack for the ack generator
    always_comb begin
        state_d = state_q;
        ack_d   = 1'b0;
        case (state_q)
            mem_pkg::ACK_IDLE: begin
                if (valid) begin
                    if (bus.we) begin
                        // the write lands at this edge so it can be acked right away
                        state_d = mem_pkg::ACK_DONE;
                        ack_d   = 1'b1;
                    end else begin
                        state_d = mem_pkg::ACK_READ_WAIT;
                    end
                end
            end
            mem_pkg::ACK_READ_WAIT: begin
                // RAM data is valid now, ack it together with the data
                if (valid) begin
                    state_d = mem_pkg::ACK_DONE;
                    ack_d   = 1'b1;
                end else begin
                    state_d = mem_pkg::ACK_IDLE;
                end
            end
            mem_pkg::ACK_DONE: begin
                // hold off further acks until the master drops stb
                if (!bus.stb) begin
                    state_d = mem_pkg::ACK_IDLE;
                end
            end
            default: begin
                state_d = mem_pkg::ACK_IDLE;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= mem_pkg::ACK_IDLE;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= ack_d;
        end
    end

    assign bus.ack = ack_q;

    // the RAM is enabled for the whole request, repeated reads return the same word
    soc_mem #(
        .WORDS (WORDS)
    ) soc_mem_i (
        .wb_clk_i (wb_clk_i),
        .ena_i    (valid),
        .wen_i    (wen),
        .addr_i   (word_adr),
        .wdata_i  (bus.dat_m2s),
        .rdata_o  (bus.dat_s2m)
    );

endmodule

// File: source/wb_addr_decoder.sv
// Wishbone address decoder for the two SRAM banks
// Steers each cycle to bank 0 or bank 1, muxes ack and read data back,
// and answers unmapped or misaligned addresses with a one-cycle err pulse.

`timescale 1ns/1ps

`include "mem_params.svh"

module wb_addr_decoder (
    input  logic        wb_clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_we_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        wb_err_o,
    wb_if.master        bank0_bus,
    wb_if.master        bank1_bus
);

    logic [31:0]         off0;
    logic [31:0]         off1;
    logic                aligned;
    logic                hit0;
    logic                hit1;
    logic                valid;
    logic                none_req;
    logic                err_q;
    logic                err_busy_q;
    mem_pkg::wb_target_e target;

    // offsets into each window
    // an address below a base wraps to a large value and fails the span check
    assign off0 = wb_adr_i - `MEM_BANK0_BASE;
    assign off1 = wb_adr_i - `MEM_BANK1_BASE;

    assign aligned = (wb_adr_i[1:0] == 2'b00);

    // a hit needs the window and a word offset below the bank depth
    assign hit0 = (off0 < `MEM_BANK_SPAN) && (off0[31:2] < 30'(`MEM_BANK0_WORDS));
    assign hit1 = (off1 < `MEM_BANK_SPAN) && (off1[31:2] < 30'(`MEM_BANK1_WORDS));

    always_comb begin
        if (aligned && hit0) begin
            target = mem_pkg::TGT_BANK0;
        end else if (aligned && hit1) begin
            target = mem_pkg::TGT_BANK1;
        end else begin
            target = mem_pkg::TGT_NONE;
        end
    end

    // request side, only the selected bank sees cyc and stb
    // the banks get the offset so that both decode from word zero
    assign bank0_bus.adr     = off0;
    assign bank0_bus.dat_m2s = wb_dat_i;
    assign bank0_bus.sel     = wb_sel_i;
    assign bank0_bus.we      = wb_we_i;
    assign bank0_bus.cyc     = wb_cyc_i & (target == mem_pkg::TGT_BANK0);
    assign bank0_bus.stb     = wb_stb_i & (target == mem_pkg::TGT_BANK0);

    assign bank1_bus.adr     = off1;
    assign bank1_bus.dat_m2s = wb_dat_i;
    assign bank1_bus.sel     = wb_sel_i;
    assign bank1_bus.we      = wb_we_i;
    assign bank1_bus.cyc     = wb_cyc_i & (target == mem_pkg::TGT_BANK1);
    assign bank1_bus.stb     = wb_stb_i & (target == mem_pkg::TGT_BANK1);

    // response side
    // the address is held until the response so the target is still valid here
    always_comb begin
        case (target)
            mem_pkg::TGT_BANK0: begin
                wb_dat_o = bank0_bus.dat_s2m;
                wb_ack_o = bank0_bus.ack;
            end
            mem_pkg::TGT_BANK1: begin
                wb_dat_o = bank1_bus.dat_s2m;
                wb_ack_o = bank1_bus.ack;
            end
            default: begin
                wb_dat_o = 32'h0;
                wb_ack_o = 1'b0;
            end
        endcase
    end

    assign valid    = wb_cyc_i & wb_stb_i;
    assign none_req = valid & (target == mem_pkg::TGT_NONE);

    // err is a one-cycle pulse per unmapped request
    // the busy flag blocks a second pulse until stb has dropped, like the bank ack
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q      <= 1'b0;
            err_busy_q <= 1'b0;
        end else begin
            err_q <= none_req & ~err_busy_q;
            if (none_req && !err_busy_q) begin
                err_busy_q <= 1'b1;
            end else if (!wb_stb_i) begin
                err_busy_q <= 1'b0;
            end
        end
    end

    assign wb_err_o = err_q;

endmodule

// File: source/mem_subsys_top.sv
// Wishbone memory subsystem top level
// Two SRAM banks of different depths behind one classic Wishbone slave port.
// The decoder picks the bank, and unmapped accesses end with err.

`timescale 1ns/1ps

`include "mem_params.svh"

module mem_subsys_top (
    input  logic        wb_clk_i,
    input  logic        rst_n_i,

    // request from the system bus master
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_we_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,

    // response back to the master
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        wb_err_o
);

    // one bus bundle between the decoder and each bank slave
    wb_if bank0_bus ();
    wb_if bank1_bus ();

    // address decode, strobe gating, response mux and err generation
    wb_addr_decoder wb_addr_decoder_i (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_we_i   (wb_we_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .bank0_bus (bank0_bus.master),
        .bank1_bus (bank1_bus.master)
    );

    // bank 0 is the larger of the two
    mem_wb #(
        .WORDS (`MEM_BANK0_WORDS)
    ) mem_wb_bank0_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus      (bank0_bus.slave)
    );

    // bank 1 sits in the second window and only fills half of the bank 0 depth
    mem_wb #(
        .WORDS (`MEM_BANK1_WORDS)
    ) mem_wb_bank1_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus      (bank1_bus.slave)
    );

endmodule

// File: verif/tb_mem_subsys.sv
// Directed testbench for the Wishbone memory subsystem
// Drives classic Wishbone cycles into both SRAM banks and into unmapped space,
// and checks read data, ack latency and err against shadow copies of the banks.

`timescale 1ns/1ps

`include "mem_params.svh"

module tb_mem_subsys;

    // the requests issued by each test size the timeout
    localparam int WORD_RW_REQS   = 12;
    localparam int BYTE_REQS      = 14;
    localparam int ISOLATION_REQS = 16;
    localparam int ERROR_REQS     = 7;
    localparam int GUARD_REQS     = 3;
    localparam int TOTAL_REQS     = WORD_RW_REQS + BYTE_REQS + ISOLATION_REQS + ERROR_REQS
                                  + GUARD_REQS;
    localparam int MAX_CYCLES     = TOTAL_REQS * 10 + 100;
    // longest wait for ack or err before an access counts as lost
    localparam int RESP_LIMIT     = 6;

    logic        wb_clk_i;
    logic        rst_n_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_we_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;

    int          error_count;
    int          cycle_count;
    logic [31:0] lcg_state;
    // shadow copies of the banks hold the expected contents
    logic [31:0] shadow0 [`MEM_BANK0_WORDS];
    logic [31:0] shadow1 [`MEM_BANK1_WORDS];

    mem_subsys_top mem_subsys_top_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o)
    );

    // 100 ns clock period
    always #50 wb_clk_i = ~wb_clk_i;

    always @(posedge wb_clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // linear congruential generator for data words
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected word after a write under a byte lane mask
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] result;
        int          lane;
        result = old_word;
        for (lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
                result[8*lane +: 8] = new_word[8*lane +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s expected %h actual %h", test, expected, actual);
        end
    endtask

    // samples ack and err at the falling edge where they are stable
    // latency counts the rising edges since the request was first sampled
    task automatic wait_response(output logic got_ack, output logic got_err,
                                 output int latency, output logic [31:0] rdata);
        got_ack = 1'b0;
        got_err = 1'b0;
        latency = 0;
        rdata   = 32'h0;
        while (!got_ack && !got_err && latency < RESP_LIMIT) begin
            @(posedge wb_clk_i);
            latency++;
            @(negedge wb_clk_i);
            got_ack = wb_ack_o;
            got_err = wb_err_o;
            rdata   = wb_dat_o;
        end
        if (!got_ack && !got_err) begin
            error_count++;
            $display("no ack or err within %0d cycles for address %h", RESP_LIMIT, wb_adr_i);
        end
        // the master drops stb in the cycle after the response
        @(posedge wb_clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic got_ack,
                            output logic got_err, output int latency);
        logic [31:0] rdata_ignored;
        @(posedge wb_clk_i);
        #1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        wb_we_i  = 1'b1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wait_response(got_ack, got_err, latency, rdata_ignored);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdata,
                           output logic got_ack, output logic got_err, output int latency);
        @(posedge wb_clk_i);
        #1;
        wb_adr_i = adr;
        wb_sel_i = 4'hf;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wait_response(got_ack, got_err, latency, rdata);
    endtask

    // a mapped write must be acked one cycle after the request
    task automatic write_word(input string test, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel);
        logic got_ack;
        logic got_err;
        int   latency;
        wb_write(adr, dat, sel, got_ack, got_err, latency);
        check_value({test, " write ack"}, 32'd1, got_ack);
        check_value({test, " write err"}, 32'd0, got_err);
        check_value({test, " write latency"}, 32'd1, latency);
    endtask

    // a mapped read is acked two cycles after the request with the data
    task automatic read_word(input string test, input logic [31:0] adr,
                             input logic [31:0] expected);
        logic [31:0] rdata;
        logic        got_ack;
        logic        got_err;
        int          latency;
        wb_read(adr, rdata, got_ack, got_err, latency);
        check_value({test, " read ack"}, 32'd1, got_ack);
        check_value({test, " read err"}, 32'd0, got_err);
        check_value({test, " read latency"}, 32'd2, latency);
        check_value({test, " read data"}, expected, rdata);
    endtask

    // an unmapped access gets err after one cycle and never an ack
    // no bank is selected then, so a read returns zero data
    task automatic access_error(input string test, input logic [31:0] adr, input logic we);
        logic [31:0] rdata;
        logic        got_ack;
        logic        got_err;
        int          latency;
        if (we) begin
            wb_write(adr, next_random(), 4'hf, got_ack, got_err, latency);
        end else begin
            wb_read(adr, rdata, got_ack, got_err, latency);
            check_value({test, " data"}, 32'h0, rdata);
        end
        check_value({test, " ack"}, 32'd0, got_ack);
        check_value({test, " err"}, 32'd1, got_err);
        check_value({test, " err latency"}, 32'd1, latency);
    endtask

    // keeps stb high for several cycles past the ack and counts the acks
    task automatic hold_access(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                               output int acks, output logic [31:0] rdata);
        int i;
        acks  = 0;
        rdata = 32'h0;
        @(posedge wb_clk_i);
        #1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = 4'hf;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        for (i = 0; i < 6; i++) begin
            @(posedge wb_clk_i);
            @(negedge wb_clk_i);
            if (wb_ack_o) begin
                acks++;
                rdata = wb_dat_o;
            end
        end
        @(posedge wb_clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic reset_quiet();
        int i;
        for (i = 0; i < 5; i++) begin
            @(negedge wb_clk_i);
            check_value("reset ack", 32'd0, wb_ack_o);
            check_value("reset err", 32'd0, wb_err_o);
        end
    endtask

    task automatic word_write_read();
        int offsets [6] = '{0, 1, 17, 100, 200, `MEM_BANK0_WORDS - 1};
        int i;
        for (i = 0; i < 6; i++) begin
            shadow0[offsets[i]] = next_random();
            write_word("word_rw", `MEM_BANK0_BASE + 4 * offsets[i], shadow0[offsets[i]], 4'hf);
        end
        for (i = 0; i < 6; i++) begin
            read_word("word_rw", `MEM_BANK0_BASE + 4 * offsets[i], shadow0[offsets[i]]);
        end
    endtask

    task automatic byte_lane_merge();
        logic [3:0]  patterns [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110, 4'b1001};
        logic [31:0] dat;
        int          i;
        shadow0[42] = next_random();
        write_word("byte_lanes", `MEM_BANK0_BASE + 4 * 42, shadow0[42], 4'hf);
        read_word("byte_lanes", `MEM_BANK0_BASE + 4 * 42, shadow0[42]);
        // only the selected bytes of the shadow word change
        for (i = 0; i < 6; i++) begin
            dat = next_random();
            write_word("byte_lanes", `MEM_BANK0_BASE + 4 * 42, dat, patterns[i]);
            shadow0[42] = merge_bytes(shadow0[42], dat, patterns[i]);
            read_word("byte_lanes", `MEM_BANK0_BASE + 4 * 42, shadow0[42]);
        end
    endtask

    task automatic bank_isolation();
        int offsets [3] = '{0, 4, `MEM_BANK1_WORDS - 1};
        int i;
        for (i = 0; i < 3; i++) begin
            shadow0[offsets[i]] = next_random();
            shadow1[offsets[i]] = ~shadow0[offsets[i]];
            write_word("isolation", `MEM_BANK0_BASE + 4 * offsets[i], shadow0[offsets[i]], 4'hf);
            write_word("isolation", `MEM_BANK1_BASE + 4 * offsets[i], shadow1[offsets[i]], 4'hf);
            read_word("isolation", `MEM_BANK0_BASE + 4 * offsets[i], shadow0[offsets[i]]);
            read_word("isolation", `MEM_BANK1_BASE + 4 * offsets[i], shadow1[offsets[i]]);
        end
        // bank 0 word 133 would land on bank 1 word 5 if the upper address bits were dropped
        shadow1[5]   = next_random();
        shadow0[133] = ~shadow1[5];
        write_word("alias", `MEM_BANK1_BASE + 4 * 5, shadow1[5], 4'hf);
        write_word("alias", `MEM_BANK0_BASE + 4 * 133, shadow0[133], 4'hf);
        read_word("alias", `MEM_BANK1_BASE + 4 * 5, shadow1[5]);
        read_word("alias", `MEM_BANK0_BASE + 4 * 133, shadow0[133]);
    endtask

    task automatic unmapped_errors();
        // the addresses past the bank depths alias onto word 0 of a 7 or 8 bit RAM address
        access_error("err bank1 depth", `MEM_BANK1_BASE + 4 * `MEM_BANK1_WORDS, 1'b1);
        access_error("err bank0 depth", `MEM_BANK0_BASE + 4 * `MEM_BANK0_WORDS, 1'b1);
        access_error("err outside", `MEM_BANK1_BASE + `MEM_BANK_SPAN, 1'b1);
        access_error("err misaligned", `MEM_BANK1_BASE + 32'h2, 1'b1);
        access_error("err read outside", 32'hffff_0000, 1'b0);
        read_word("err unchanged", `MEM_BANK0_BASE, shadow0[0]);
        read_word("err unchanged", `MEM_BANK1_BASE, shadow1[0]);
    endtask

    task automatic single_ack_guard();
        logic [31:0] rdata;
        int          acks;
        shadow1[9] = next_random();
        hold_access(`MEM_BANK1_BASE + 4 * 9, 1'b1, shadow1[9], acks, rdata);
        check_value("ack_guard write acks", 32'd1, acks);
        hold_access(`MEM_BANK1_BASE + 4 * 9, 1'b0, 32'h0, acks, rdata);
        check_value("ack_guard read acks", 32'd1, acks);
        check_value("ack_guard read data", shadow1[9], rdata);
        read_word("ack_guard", `MEM_BANK1_BASE + 4 * 9, shadow1[9]);
    endtask

    initial begin
        wb_clk_i    = 1'b0;
        rst_n_i     = 1'b0;
        wb_adr_i    = 32'h0;
        wb_dat_i    = 32'h0;
        wb_sel_i    = 4'h0;
        wb_we_i     = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        error_count = 0;
        cycle_count = 0;
        lcg_state   = 32'hf5bc_4b3f;
        repeat (3) @(posedge wb_clk_i);
        #1;
        rst_n_i = 1'b1;
        reset_quiet();
        word_write_read();
        byte_lane_merge();
        bank_isolation();
        unmapped_errors();
        single_ack_guard();
        $display("checks done with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/mem_pkg.sv
source/wb_if.sv
source/soc_mem.sv
source/mem_wb.sv
source/wb_addr_decoder.sv
source/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/wb_if.sv
      - source/soc_mem.sv
      - source/mem_wb.sv
      - source/wb_addr_decoder.sv
      - source/mem_subsys_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_mem_subsys.sv
